//--- rtl/cus41_consts.svh
`ifndef CUS41_CONSTS_SVH
`define CUS41_CONSTS_SVH

//////////////////////////////////////////////////
// Watchdog
//////////////////////////////////////////////////

// Default counter width
// The main reset trips after 2^(width-1) vertical blanks
`define CUS41_WDOG_WIDTH 8

//////////////////////////////////////////////////
// Page codes on address bits 15 to 11
//////////////////////////////////////////////////

// Main CPU watchdog kick page at 8000h to 87FFh
`define CUS41_WDOG_PAGE 5'b10000
// Main CPU interrupt acknowledge page at 8800h to 8FFFh
`define CUS41_ACK_PAGE 5'b10001
// Scroll and priority latches for layer pair 0 at D000h
`define CUS41_LTH0_PAGE 5'b11010
// Scroll and priority latches for layer pair 1 at D800h
`define CUS41_LTH1_PAGE 5'b11011
// Sub CPU sound RAM page at 4000h to 47FFh
`define CUS41_SND_PAGE 5'b01000

`endif

//--- rtl/addrMapPkg.sv
package addrMapPkg;

        //////////////////////////////////////////////////
        // CPU bus inputs
        //////////////////////////////////////////////////

        // Main CPU upper address lines and write strobe
        typedef struct packed {
                logic [15:11] addr;
                // Low during a write cycle
                logic         weN;
        } mainBus_t;

        // Sub CPU upper address lines and write strobe
        typedef struct packed {
                logic [15:11] addr;
                logic         weN;
        } subBus_t;

        //////////////////////////////////////////////////
        // Chip select outputs
        //////////////////////////////////////////////////

        // Main selects are all active low
        typedef struct packed {
                logic mcs0N;   // Video RAM 1
                logic mcs1N;   // Video RAM 2
                logic mcs2N;   // Sprite RAM
                logic mcs3N;   // Unused on this board
                logic mcs4N;   // Banked ROM window
                logic mromN;   // Program ROM
                logic lth0N;
                logic lth1N;
        } mainSel_t;

        // Sub selects are active high except the sound RAM
        typedef struct packed {
                logic scs0;
                logic scs1;
                logic scs2;
                logic scs3;
                logic scs4;
                logic srom;
                logic sndN;
        } subSel_t;

endpackage

//--- rtl/sysCtrlPkg.sv
package sysCtrlPkg;

        //////////////////////////////////////////////////
        // Control events from the main decode
        //////////////////////////////////////////////////

        // One-cycle strobes
        typedef struct packed {
                // Clears the sub CPU interrupt
                logic irqAck;
                // Clears the watchdog counter
                logic wdogKick;
        } ctrlEvt_t;

        //////////////////////////////////////////////////
        // Board level control outputs
        //////////////////////////////////////////////////

        // Both active low
        typedef struct packed {
                // Sub CPU interrupt request
                logic sintN;
                // Main CPU reset from the watchdog
                logic mresN;
        } ctrlOut_t;

endpackage

//--- rtl/mainDecode.sv
`timescale 1ns/1ps
`include "cus41_consts.svh"

module mainDecode (
        input  logic                 clk6M,
        input  logic                 rstN,
        input  addrMapPkg::mainBus_t mainBus,
        output addrMapPkg::mainSel_t mainSel,
        output sysCtrlPkg::ctrlEvt_t ctrlEvt
);

        // 8K region index from the top three address bits
        logic [2:0] region;
        // Full 2K page code
        logic [4:0] page;
        // Write decodes before registering
        logic       ackWr;
        logic       kickWr;

        assign region = mainBus.addr[15:13];
        assign page   = mainBus.addr[15:11];

        //////////////////////////////////////////////////
        // Chip selects
        //////////////////////////////////////////////////

        // Pure address decode
        // Reads and writes select alike
        always_comb begin
                // Sprite RAM at 0000h to 1FFFh
                mainSel.mcs2N = (region != 3'b000);
                // Video RAM 1 at 2000h to 3FFFh
                mainSel.mcs0N = (region != 3'b001);
                // Video RAM 2 at 4000h to 5FFFh
                mainSel.mcs1N = (region != 3'b010);
                // Banked ROM window at 6000h to 7FFFh
                mainSel.mcs4N = (region != 3'b011);
                // Never selected
                mainSel.mcs3N = 1'b1;
                // Program ROM covers the whole upper half
                mainSel.mromN = ~mainBus.addr[15];
                // Scroll and priority latch pages
                // These overlap the program ROM window on purpose
                mainSel.lth0N = (page != `CUS41_LTH0_PAGE);
                mainSel.lth1N = (page != `CUS41_LTH1_PAGE);
        end

        //////////////////////////////////////////////////
        // Control strobes
        //////////////////////////////////////////////////

        // Writes only
        // Any address inside the 2K page counts
        assign ackWr  = ~mainBus.weN && (page == `CUS41_ACK_PAGE);
        assign kickWr = ~mainBus.weN && (page == `CUS41_WDOG_PAGE);

        // One register stage
        // A single-cycle write gives a single-cycle strobe
        always_ff @(posedge clk6M or negedge rstN) begin
                if (!rstN) begin
                        ctrlEvt <= '0;
                end else begin
                        ctrlEvt.irqAck   <= ackWr;
                        ctrlEvt.wdogKick <= kickWr;
                end
        end

endmodule

//--- rtl/subDecode.sv
`timescale 1ns/1ps
`include "cus41_consts.svh"

module subDecode (
        input  addrMapPkg::subBus_t subBus,
        output addrMapPkg::subSel_t subSel
);

        // Sub CPU latch page at 8000h to 87FFh
        localparam logic [4:0] latchPage = 5'b10000;

        // 8K region index
        logic [2:0] region;
        // 2K page code
        logic [4:0] page;
        // Sound RAM page hit
        logic       sndHit;

        assign region = subBus.addr[15:13];
        assign page   = subBus.addr[15:11];
        assign sndHit = (page == `CUS41_SND_PAGE);

        //////////////////////////////////////////////////
        // Select decode
        //////////////////////////////////////////////////

        always_comb begin
                // Shared RAM at 0000h to 1FFFh
                subSel.scs0 = (region == 3'b000);
                // Shared RAM at 2000h to 3FFFh
                subSel.scs1 = (region == 3'b001);

                // Sound RAM takes the first 2K of the 4000h window
                subSel.sndN = ~sndHit;
                // Rest of that window at 4800h to 5FFFh
                subSel.scs2 = (region == 3'b010) && !sndHit;

                // 6000h to 7FFFh
                subSel.scs3 = (region == 3'b011);

                // 8000h page is a write latch
                subSel.scs4 = (page == latchPage) && !subBus.weN;
                // Reads of the upper half go to the sub ROM
                // so a write there never reaches the ROM
                subSel.srom = subBus.addr[15] && subBus.weN;
        end

endmodule

//--- rtl/vblankIrq.sv
`timescale 1ns/1ps

module vblankIrq (
        input  logic clk6M,
        input  logic rstN,
        input  logic vblaN,
        input  logic irqAck,
        output logic vblankStart,
        output logic sintN
);

        // Previous sample of vertical blank
        logic vblaQ;

        //////////////////////////////////////////////////
        // Edge detect
        //////////////////////////////////////////////////

        // Reset value is high so a blank already active
        // at reset does not count as a new start
        always_ff @(posedge clk6M or negedge rstN) begin
                if (!rstN) begin
                        vblaQ <= 1'b1;
                end else begin
                        vblaQ <= vblaN;
                end
        end

        // High while the last sample was high and the line is now low
        // Consumed at the next rising edge
        assign vblankStart = vblaQ && !vblaN;

        //////////////////////////////////////////////////
        // Interrupt latch
        //////////////////////////////////////////////////

        // Set by the start of vertical blank
        // Cleared by the main CPU acknowledge strobe
        always_ff @(posedge clk6M or negedge rstN) begin
                if (!rstN) begin
                        sintN <= 1'b1;
                end else if (vblankStart) begin
                        // Set takes priority over a coincident acknowledge
                        sintN <= 1'b0;
                end else if (irqAck) begin
                        sintN <= 1'b1;
                end
        end

endmodule

//--- rtl/watchdog.sv
`timescale 1ns/1ps
`include "cus41_consts.svh"

module watchdog #(
        parameter int width = `CUS41_WDOG_WIDTH
) (
        input  logic clk6M,
        input  logic rstN,
        input  logic vblankStart,
        input  logic wdogKick,
        output logic mresN
);

        // Vertical blanks since the last kick
        logic [width-1:0] count;
        // Top bit reached
        logic             tripped;

        assign tripped = count[width-1];

        //////////////////////////////////////////////////
        // Counter
        //////////////////////////////////////////////////

        always_ff @(posedge clk6M or negedge rstN) begin
                if (!rstN) begin
                        count <= '0;
                end else if (wdogKick) begin
                        // Kick wins over a coincident vblank
                        count <= '0;
                end else if (vblankStart && !tripped) begin
                        // Hold once tripped
                        // so the reset stays asserted until a kick
                        count <= count + 1'b1;
                end
        end

        // Main CPU held in reset while the top bit is set
        assign mresN = ~tripped;

endmodule

//--- rtl/cus41.sv
`timescale 1ns/1ps
`include "cus41_consts.svh"

module cus41 #(
        parameter int wdogWidth = `CUS41_WDOG_WIDTH
) (
        input  logic                 clk6M,
        input  logic                 rstN,
        input  addrMapPkg::mainBus_t mainBus,
        input  addrMapPkg::subBus_t  subBus,
        input  logic                 vblaN,
        output addrMapPkg::mainSel_t mainSel,
        output addrMapPkg::subSel_t  subSel,
        output sysCtrlPkg::ctrlOut_t ctrl
);

        // Strobes from the main decode
        sysCtrlPkg::ctrlEvt_t ctrlEvt;
        // Vertical blank start toward the watchdog
        logic                 vblankStart;
        // Control outputs before packing
        logic                 sintN;
        logic                 mresN;

        //////////////////////////////////////////////////
        // Address decode
        //////////////////////////////////////////////////

        // Main CPU selects and control strobes
        mainDecode mainDecode_i (
                .clk6M   (clk6M),
                .rstN    (rstN),
                .mainBus (mainBus),
                .mainSel (mainSel),
                .ctrlEvt (ctrlEvt)
        );

        // Sub CPU selects
        subDecode subDecode_i (
                .subBus (subBus),
                .subSel (subSel)
        );

        //////////////////////////////////////////////////
        // Control
        //////////////////////////////////////////////////

        // Sub CPU interrupt from vertical blank
        vblankIrq vblankIrq_i (
                .clk6M       (clk6M),
                .rstN        (rstN),
                .vblaN       (vblaN),
                .irqAck      (ctrlEvt.irqAck),
                .vblankStart (vblankStart),
                .sintN       (sintN)
        );

        // Main CPU reset on missed kicks
        watchdog #(
                .width (wdogWidth)
        ) watchdog_i (
                .clk6M       (clk6M),
                .rstN        (rstN),
                .vblankStart (vblankStart),
                .wdogKick    (ctrlEvt.wdogKick),
                .mresN       (mresN)
        );

        // Board outputs
        assign ctrl.sintN = sintN;
        assign ctrl.mresN = mresN;

endmodule

//--- bench/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
        parameter int halfPeriodNs = 20,
        parameter int resetCycles  = 16
) (
        output logic clk6M,
        output logic rstN
);

        // Free running clock with a 40 ns period by default
        initial begin
                clk6M = 1'b0;
                forever begin
                        #(halfPeriodNs) clk6M = ~clk6M;
                end
        end

        // Reset held over the first cycles
        // Released on a falling edge like every other input
        initial begin
                rstN = 1'b0;
                repeat (resetCycles) @(posedge clk6M);
                @(negedge clk6M);
                rstN = 1'b1;
        end

endmodule

//--- bench/cus41Tb.sv
`timescale 1ns/1ps
`include "cus41_consts.svh"

module cus41Tb;

        // Small watchdog so the reset trips after 8 blanks
        localparam int wdogWidth = 4;
        localparam int tripLimit = 1 << (wdogWidth - 1);
        localparam addrMapPkg::mainBus_t mainIdle = '{addr: 5'b00000, weN: 1'b1};
        localparam addrMapPkg::subBus_t  subIdle  = '{addr: 5'b00000, weN: 1'b1};

        logic                 clk6M;
        logic                 rstN;
        addrMapPkg::mainBus_t mainBus;
        addrMapPkg::subBus_t  subBus;
        logic                 vblaN;
        addrMapPkg::mainSel_t mainSel;
        addrMapPkg::subSel_t  subSel;
        sysCtrlPkg::ctrlOut_t ctrl;

        int          mismatchCount = 0;
        int          timeoutCount  = 0;
        logic [31:0] lfsrState     = 32'h796523b5;

        clockGen clockGen_i (.clk6M(clk6M), .rstN(rstN));

        cus41 #(.wdogWidth(wdogWidth)) dut_i (
                .clk6M   (clk6M),
                .rstN    (rstN),
                .mainBus (mainBus),
                .subBus  (subBus),
                .vblaN   (vblaN),
                .mainSel (mainSel),
                .subSel  (subSel),
                .ctrl    (ctrl)
        );

        //////////////////////////////////////////////////
        // Reference model
        //////////////////////////////////////////////////

        // Main map from the full byte address of the page
        function automatic addrMapPkg::mainSel_t expectMainSel(addrMapPkg::mainBus_t bus);
                logic [15:0]          a;
                addrMapPkg::mainSel_t s;
                a       = {bus.addr, 11'h000};
                s.mcs2N = !(a <= 16'h1FFF);
                s.mcs0N = !(a >= 16'h2000 && a <= 16'h3FFF);
                s.mcs1N = !(a >= 16'h4000 && a <= 16'h5FFF);
                s.mcs4N = !(a >= 16'h6000 && a <= 16'h7FFF);
                s.mcs3N = 1'b1;
                s.mromN = !(a >= 16'h8000);
                s.lth0N = !(bus.addr == `CUS41_LTH0_PAGE);
                s.lth1N = !(bus.addr == `CUS41_LTH1_PAGE);
                return s;
        endfunction

        // Sub map with the sound page cut out of the 4000h window
        function automatic addrMapPkg::subSel_t expectSubSel(addrMapPkg::subBus_t bus);
                logic [15:0]         a;
                addrMapPkg::subSel_t s;
                a      = {bus.addr, 11'h000};
                s.scs0 = (a <= 16'h1FFF);
                s.scs1 = (a >= 16'h2000 && a <= 16'h3FFF);
                s.sndN = !(a >= 16'h4000 && a <= 16'h47FF);
                s.scs2 = (a >= 16'h4800 && a <= 16'h5FFF);
                s.scs3 = (a >= 16'h6000 && a <= 16'h7FFF);
                s.scs4 = (a >= 16'h8000 && a <= 16'h87FF) && !bus.weN;
                s.srom = (a >= 16'h8000) && bus.weN;
                return s;
        endfunction

        logic refVblaPrev;
        logic refAckPend;
        logic refKickPend;
        logic refSintN;
        int   refBlanks;
        logic refMresN;

        // Strobes one cycle late
        // Interrupt latch and blank counter
        always_ff @(posedge clk6M or negedge rstN) begin
                if (!rstN) begin
                        refVblaPrev <= 1'b1;
                        refAckPend  <= 1'b0;
                        refKickPend <= 1'b0;
                        refSintN    <= 1'b1;
                        refBlanks   <= 0;
                end else begin
                        refVblaPrev <= vblaN;
                        refAckPend  <= !mainBus.weN && (mainBus.addr == `CUS41_ACK_PAGE);
                        refKickPend <= !mainBus.weN && (mainBus.addr == `CUS41_WDOG_PAGE);
                        // Set beats acknowledge
                        if (refVblaPrev && !vblaN) begin
                                refSintN <= 1'b0;
                        end else if (refAckPend) begin
                                refSintN <= 1'b1;
                        end
                        // Kick beats a blank
                        // Count saturates at the trip point
                        if (refKickPend) begin
                                refBlanks <= 0;
                        end else if (refVblaPrev && !vblaN && refBlanks < tripLimit) begin
                                refBlanks <= refBlanks + 1;
                        end
                end
        end

        assign refMresN = (refBlanks < tripLimit);

        //////////////////////////////////////////////////
        // Assertions
        //////////////////////////////////////////////////

        mainSelMatch: assert property (@(posedge clk6M) disable iff (!rstN)
                mainSel == expectMainSel(mainBus))
        else begin
                mismatchCount++;
                $display("MISMATCH time=%0t signal=mainSel expected=%b actual=%b", $time,
                         expectMainSel($sampled(mainBus)), $sampled(mainSel));
        end

        subSelMatch: assert property (@(posedge clk6M) disable iff (!rstN)
                subSel == expectSubSel(subBus))
        else begin
                mismatchCount++;
                $display("MISMATCH time=%0t signal=subSel expected=%b actual=%b", $time,
                         expectSubSel($sampled(subBus)), $sampled(subSel));
        end

        sintMatch: assert property (@(posedge clk6M) disable iff (!rstN)
                ctrl.sintN == refSintN)
        else begin
                mismatchCount++;
                $display("MISMATCH time=%0t signal=sintN expected=%b actual=%b", $time,
                         $sampled(refSintN), $sampled(ctrl.sintN));
        end

        mresMatch: assert property (@(posedge clk6M) disable iff (!rstN)
                ctrl.mresN == refMresN)
        else begin
                mismatchCount++;
                $display("MISMATCH time=%0t signal=mresN expected=%b actual=%b", $time,
                         $sampled(refMresN), $sampled(ctrl.mresN));
        end

        // Interrupt one edge after the blank edge even with an acknowledge
        vblankToIrq: assert property (@(posedge clk6M) disable iff (!rstN)
                $fell(vblaN) |=> !ctrl.sintN)
        else begin
                mismatchCount++;
                $display("MISMATCH time=%0t signal=sintN expected=0 actual=%b", $time,
                         $sampled(ctrl.sintN));
        end

        //////////////////////////////////////////////////
        // Stimulus helpers
        //////////////////////////////////////////////////

        // Galois form of x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsrNext(input logic [31:0] s);
                if (s[0]) begin
                        return (s >> 1) ^ 32'h80200003;
                end
                return s >> 1;
        endfunction

        // One step per bit taken
        task automatic takeBits(input int count, output logic [7:0] bits);
                bits = '0;
                for (int i = 0; i < count; i++) begin
                        bits      = {bits[6:0], lfsrState[0]};
                        lfsrState = lfsrNext(lfsrState);
                end
        endtask

        task automatic waitResetRelease();
                int n;
                n = 0;
                while (!rstN && n < 40) begin
                        @(negedge clk6M);
                        n++;
                end
                if (!rstN) begin
                        timeoutCount++;
                        $display("ERROR: reset was never released");
                end
        endtask

        // Polls sintN or mresN on falling edges
        task automatic waitForCtrl(input bit watchSint, input logic level, input int limit);
                int   n;
                logic value;
                n     = 0;
                value = watchSint ? ctrl.sintN : ctrl.mresN;
                while (value !== level && n < limit) begin
                        @(negedge clk6M);
                        n++;
                        value = watchSint ? ctrl.sintN : ctrl.mresN;
                end
                if (value !== level) begin
                        timeoutCount++;
                        $display("ERROR: %s did not reach %b within %0d cycles",
                                 watchSint ? "sintN" : "mresN", level, limit);
                end
        endtask

        // Single cycle write to one main page
        task automatic mainWrite(input logic [4:0] page);
                @(negedge clk6M);
                mainBus.addr = page;
                mainBus.weN  = 1'b0;
                @(negedge clk6M);
                mainBus      = mainIdle;
        endtask

        // Blank lasts a few cycles
        task automatic pulseVblank();
                @(negedge clk6M);
                vblaN = 1'b0;
                waitForCtrl(1'b1, 1'b0, 4);
                repeat (3) @(negedge clk6M);
                vblaN = 1'b1;
                @(negedge clk6M);
        endtask

        //////////////////////////////////////////////////
        // Test sequence
        //////////////////////////////////////////////////

        initial begin
                logic [7:0] pageBits;
                logic [7:0] weBit;
                mainBus = mainIdle;
                subBus  = subIdle;
                vblaN   = 1'b1;
                waitResetRelease();

                // Quiet after reset
                repeat (10) @(negedge clk6M);

                // Random main addresses
                repeat (400) begin
                        @(negedge clk6M);
                        takeBits(5, pageBits);
                        takeBits(1, weBit);
                        mainBus.addr = pageBits[4:0];
                        mainBus.weN  = weBit[0];
                end
                @(negedge clk6M);
                mainBus = mainIdle;

                // Random sub addresses
                repeat (400) begin
                        @(negedge clk6M);
                        takeBits(5, pageBits);
                        takeBits(1, weBit);
                        subBus.addr = pageBits[4:0];
                        subBus.weN  = weBit[0];
                end
                @(negedge clk6M);
                subBus = subIdle;

                // Interrupt set and acknowledge
                pulseVblank();
                mainWrite(`CUS41_ACK_PAGE);
                waitForCtrl(1'b1, 1'b1, 4);

                // Acknowledge strobe in the same cycle as a new blank
                pulseVblank();
                @(negedge clk6M);
                mainBus.addr = `CUS41_ACK_PAGE;
                mainBus.weN  = 1'b0;
                @(negedge clk6M);
                mainBus = mainIdle;
                vblaN   = 1'b0;
                repeat (4) @(negedge clk6M);
                vblaN = 1'b1;
                mainWrite(`CUS41_ACK_PAGE);
                waitForCtrl(1'b1, 1'b1, 4);

                // Watchdog trip after eight blanks, then recovery
                mainWrite(`CUS41_WDOG_PAGE);
                repeat (tripLimit) pulseVblank();
                waitForCtrl(1'b0, 1'b0, 4);
                mainWrite(`CUS41_WDOG_PAGE);
                waitForCtrl(1'b0, 1'b1, 4);

                // Regular kicks keep the main CPU running
                for (int i = 0; i < 12; i++) begin
                        pulseVblank();
                        if (i % 3 == 2) begin
                                mainWrite(`CUS41_WDOG_PAGE);
                        end
                end
                repeat (4) @(negedge clk6M);

                $display("Summary: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
                if (mismatchCount == 0 && timeoutCount == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

endmodule

//--- sources.f
+incdir+rtl
rtl/addrMapPkg.sv
rtl/sysCtrlPkg.sv
rtl/mainDecode.sv
rtl/subDecode.sv
rtl/vblankIrq.sv
rtl/watchdog.sv
rtl/cus41.sv
bench/clockGen.sv
bench/cus41Tb.sv

//--- Bender.yml
package:
  name: cus41

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/addrMapPkg.sv
      - rtl/sysCtrlPkg.sv
      - rtl/mainDecode.sv
      - rtl/subDecode.sv
      - rtl/vblankIrq.sv
      - rtl/watchdog.sv
      - rtl/cus41.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/clockGen.sv
      - bench/cus41Tb.sv
